// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0 -Wno-fatal
TOP      = tb_resampler
FILELIST = filelist.f
PASS_MSG = Finished with no errors

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST)) verif/resampler_model.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulator output
run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== common/firbank_pkg.sv ====
// coefficient type and the coefficient rule of the polyphase bank
`default_nettype none

package firbank_pkg;

    typedef logic signed [23:0] coef_t;

    // triangular window over the full 2*halfdepth taps,
    // peak at depth 0 of each wing, scaled by (phase+1)/num_fir
    // so the largest entry is half of full scale
    function automatic coef_t coef_value(
        input int phase,
        input int depth,
        input int num_fir,
        input int halfdepth
    );
        longint num;
        longint den;
        num = (longint'(1) << 22) * longint'(halfdepth - depth) * longint'(phase + 1);
        den = longint'(halfdepth) * longint'(num_fir);
        return coef_t'(num / den);
    endfunction

endpackage

`default_nettype wire

// ==== common/sample_pkg.sv ====
// sample, product and accumulator types, product scaling and saturating arithmetic
`default_nettype none

package sample_pkg;

    typedef logic signed [23:0] sample_t;
    typedef logic signed [27:0] product_t;
    typedef logic signed [31:0] acc_t;

    localparam int PRODUCT_SHIFT = 20;
    localparam int MULT_LATENCY = 5;   // multiplier pipeline depth

    // full 48-bit product down to product_t
    function automatic product_t scale_product(input logic signed [47:0] full);
        logic signed [47:0] shifted;
        shifted = full >>> PRODUCT_SHIFT;
        return shifted[27:0];
    endfunction

    // clamps to 32-bit limits on overflow
    function automatic acc_t sat_add_acc(input acc_t a, input acc_t b);
        logic signed [32:0] sum;
        sum = {a[31], a} + {b[31], b};
        if (sum[32] != sum[31]) begin
            return sum[32] ? 32'h8000_0000 : 32'h7fff_ffff;
        end
        return sum[31:0];
    endfunction

    // drop 4 guard bits, then clamp to 24 bits
    function automatic sample_t acc_to_sample(input acc_t a);
        acc_t s;
        s = a >>> 4;
        if (s > 32'sd8388607) begin
            return 24'h7f_ffff;
        end
        if (s < -32'sd8388608) begin
            return 24'h80_0000;
        end
        return s[23:0];
    endfunction

endpackage

`default_nettype wire

// ==== design/firbank.sv ====
// polyphase coefficient ROM with registered read
`timescale 1ns/100ps
`default_nettype none

module firbank #(
    parameter int NUM_FIR = 20,
    parameter int HALFDEPTH = 8,
    localparam int FIR_W = $clog2(NUM_FIR),
    localparam int HD_W = $clog2(HALFDEPTH),
    localparam int ADDR_W = FIR_W + HD_W
) (
    input wire logic clk,
    input wire logic [ADDR_W-1:0] addr_i,
    output firbank_pkg::coef_t data_o
);
    import firbank_pkg::*;

    coef_t rom [2**ADDR_W];

    // address is {phase, depth}, unused phases read zero
    initial begin
        for (int p = 0; p < 2**FIR_W; p++) begin
            for (int d = 0; d < HALFDEPTH; d++) begin
                if (p < NUM_FIR) begin
                    rom[p * HALFDEPTH + d] = coef_value(p, d, NUM_FIR, HALFDEPTH);
                end else begin
                    rom[p * HALFDEPTH + d] = '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        data_o <= rom[addr_i];
    end

endmodule

`default_nettype wire

// ==== design/resampler_top.sv ====
// resampler top: ring buffer array, core with multiplier, coefficient bank
`timescale 1ns/100ps
`default_nettype none

module resampler_top #(
    parameter int NUM_CH = 4,
    parameter int HALFDEPTH = 8,
    parameter int NUM_FIR = 20,
    parameter int DECIM = 17,
    parameter int TIMESLICE = 32,
    localparam int HD_W = $clog2(HALFDEPTH),
    localparam int FIR_W = $clog2(NUM_FIR)
) (
    input wire logic clk,
    input wire logic rst,

    // upstream source
    input wire logic [NUM_CH-1:0] ack_i,
    input wire logic [NUM_CH*24-1:0] data_i,
    output logic [NUM_CH-1:0] pop_o,

    // consumer
    input wire logic [NUM_CH-1:0] pop_i,
    output sample_pkg::sample_t data_o,
    output logic [NUM_CH-1:0] ack_o
);
    import firbank_pkg::*;

    logic [FIR_W+HD_W-1:0] bank_addr;
    coef_t bank_data;
    logic [HD_W:0] rb_offset;
    logic [NUM_CH*24-1:0] rb_data;

    // 4x window depth absorbs source jitter
    for (genvar g = 0; g < NUM_CH; g++) begin : g_rb
        ringbuf #(
            .LEN(4 * HALFDEPTH)
        ) u_rb (
            .clk(clk),
            .rst(rst),
            .data_i(data_i[24*g +: 24]),
            .we_i(ack_i[g]),
            .pop_i(pop_o[g]),
            .offset_i(rb_offset),
            .data_o(rb_data[24*g +: 24])
        );
    end

    resampler_core #(
        .NUM_CH(NUM_CH),
        .HALFDEPTH(HALFDEPTH),
        .NUM_FIR(NUM_FIR),
        .DECIM(DECIM),
        .TIMESLICE(TIMESLICE)
    ) u_core (
        .clk(clk),
        .rst(rst),
        .bank_addr_o(bank_addr),
        .bank_data_i(bank_data),
        .pop_o(pop_o),
        .offset_o(rb_offset),
        .data_i(rb_data),
        .pop_i(pop_i),
        .data_o(data_o),
        .ack_o(ack_o)
    );

    firbank #(
        .NUM_FIR(NUM_FIR),
        .HALFDEPTH(HALFDEPTH)
    ) u_bank (
        .clk(clk),
        .addr_i(bank_addr),
        .data_o(bank_data)
    );

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+verif
common/sample_pkg.sv
common/firbank_pkg.sv
resampler/mpemu.sv
resampler/ringbuf.sv
resampler/resampler_core.sv
design/firbank.sv
design/resampler_top.sv
verif/tb_resampler.sv

// ==== resampler/mpemu.sv ====
// pipelined signed multiplier with fixed latency and scaled product output
`timescale 1ns/100ps
`default_nettype none

module mpemu (
    input wire logic clk,
    input wire sample_pkg::sample_t sample_i,
    input wire firbank_pkg::coef_t coef_i,
    output sample_pkg::product_t prod_o
);
    import sample_pkg::*;

    logic signed [47:0] pipe_q [MULT_LATENCY];

    always_ff @(posedge clk) begin
        pipe_q[0] <= sample_i * coef_i;
        for (int i = 1; i < MULT_LATENCY; i++) begin
            pipe_q[i] <= pipe_q[i-1];   // retiming stages
        end
    end

    assign prod_o = scale_product(pipe_q[MULT_LATENCY-1]);

endmodule

`default_nettype wire

// ==== resampler/resampler_core.sv ====
// timeslice scheduler, wing sequencer, phase accumulators, address generation and accumulator
`timescale 1ns/100ps
`default_nettype none

module resampler_core #(
    parameter int NUM_CH = 4,
    parameter int HALFDEPTH = 8,
    parameter int NUM_FIR = 20,
    parameter int DECIM = 17,
    parameter int TIMESLICE = 32,
    localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1,
    localparam int HD_W = $clog2(HALFDEPTH),
    localparam int FIR_W = $clog2(NUM_FIR),
    localparam int TS_W = $clog2(TIMESLICE)
) (
    input wire logic clk,
    input wire logic rst,

    // coefficient bank
    output logic [FIR_W+HD_W-1:0] bank_addr_o,
    input wire firbank_pkg::coef_t bank_data_i,

    // ring buffers
    output logic [NUM_CH-1:0] pop_o,
    output logic [HD_W:0] offset_o,
    input wire logic [NUM_CH*24-1:0] data_i,

    // consumer
    input wire logic [NUM_CH-1:0] pop_i,
    output sample_pkg::sample_t data_o,
    output logic [NUM_CH-1:0] ack_o
);
    import sample_pkg::*;

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_READY = 3'd1;
    localparam logic [2:0] ST_RWING = 3'd2;
    localparam logic [2:0] ST_LWING = 3'd3;
    localparam logic [2:0] ST_WAIT  = 3'd4;
    localparam logic [2:0] ST_SAT   = 3'd5;
    localparam logic [2:0] ST_END   = 3'd6;
    localparam int CNT_W = $clog2(HALFDEPTH + MULT_LATENCY + 1);

    logic [TS_W-1:0] slot_cnt;
    logic [CH_W-1:0] ch_q;
    logic slot_start;
    logic [NUM_CH-1:0] ch_onehot;
    logic [NUM_CH-1:0] req_q;
    logic [2:0] state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [FIR_W-1:0] phase_mem [NUM_CH];
    logic [FIR_W-1:0] firidx_l;
    logic [FIR_W-1:0] firidx_r;
    logic lwing;
    logic in_wing;
    logic [HD_W-1:0] wing_pos;
    logic [HD_W-1:0] depth;
    sample_t smp;
    product_t prod;
    logic [MULT_LATENCY:0] tap_q;
    acc_t sum_q;

    assign slot_start = (slot_cnt == '0);
    assign ch_onehot = NUM_CH'(1) << ch_q;

    // fixed rotation, one channel per timeslice
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_cnt <= '0;
            ch_q <= '0;
        end else if (slot_cnt == TS_W'(TIMESLICE - 1)) begin
            slot_cnt <= '0;
            ch_q <= (ch_q == CH_W'(NUM_CH - 1)) ? '0 : ch_q + 1'b1;
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    // requests held until the channel's slot begins
    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= '0;
        end else if (slot_start) begin
            req_q <= (req_q & ~ch_onehot) | pop_i;
        end else begin
            req_q <= req_q | pop_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            cnt_q <= '0;
        end else if (slot_start) begin
            state_q <= req_q[ch_q] ? ST_READY : ST_IDLE;
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
            case (state_q)
                ST_READY: begin
                    state_q <= ST_RWING;
                    cnt_q <= '0;
                end
                ST_RWING: begin
                    if (cnt_q == CNT_W'(HALFDEPTH - 1)) begin
                        state_q <= ST_LWING;
                        cnt_q <= '0;
                    end
                end
                ST_LWING: begin
                    if (cnt_q == CNT_W'(HALFDEPTH - 1)) begin
                        state_q <= ST_WAIT;
                        cnt_q <= '0;
                    end
                end
                ST_WAIT: begin
                    if (cnt_q == CNT_W'(MULT_LATENCY)) state_q <= ST_SAT;   // rom + mult drain
                end
                ST_SAT: state_q <= ST_END;
                ST_END: state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_READY) begin
            firidx_l <= phase_mem[ch_q];
            firidx_r <= FIR_W'(NUM_FIR - 1) - phase_mem[ch_q];   // mirrored phase
        end
    end

    // phase advance and input pop, one cycle after the end cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pop_o <= '0;
            for (int i = 0; i < NUM_CH; i++) begin
                phase_mem[i] <= '0;
            end
        end else begin
            pop_o <= '0;
            if (state_q == ST_END) begin
                if (firidx_l >= FIR_W'(NUM_FIR - DECIM)) begin
                    phase_mem[ch_q] <= FIR_W'(firidx_l + DECIM - NUM_FIR);
                    pop_o <= ch_onehot;
                end else begin
                    phase_mem[ch_q] <= FIR_W'(firidx_l + DECIM);
                end
            end
        end
    end

    // right wing walks depth down, left wing walks it up
    assign lwing = (state_q == ST_LWING);
    assign in_wing = (state_q == ST_RWING) || lwing;
    assign wing_pos = HD_W'(HALFDEPTH - 1) - cnt_q[HD_W-1:0];
    assign depth = lwing ? cnt_q[HD_W-1:0] : wing_pos;
    assign bank_addr_o = {lwing ? firidx_l : firidx_r, depth};
    assign offset_o = {~lwing, wing_pos};   // upper half of window for the right wing

    assign smp = data_i[ch_q*24 +: 24];

    mpemu u_mpemu (
        .clk(clk),
        .sample_i(smp),
        .coef_i(bank_data_i),
        .prod_o(prod)
    );

    // marks which products in flight belong to a wing
    always_ff @(posedge clk) begin
        if (rst) begin
            tap_q <= '0;
        end else begin
            tap_q <= {tap_q[MULT_LATENCY-1:0], in_wing};
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_READY) begin
            sum_q <= '0;
        end else if (tap_q[MULT_LATENCY]) begin
            sum_q <= sat_add_acc(sum_q, acc_t'(prod));
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_SAT) data_o <= acc_to_sample(sum_q);
    end

    assign ack_o = (state_q == ST_END) ? ch_onehot : '0;

endmodule

`default_nettype wire

// ==== resampler/ringbuf.sv ====
// circular sample buffer with write pointer, pop-advanced read pointer and offset read
`timescale 1ns/100ps
`default_nettype none

module ringbuf #(
    parameter int LEN = 32,
    localparam int PTR_W = $clog2(LEN)
) (
    input wire logic clk,
    input wire logic rst,
    input wire sample_pkg::sample_t data_i,
    input wire logic we_i,
    input wire logic pop_i,
    input wire logic [PTR_W-2:0] offset_i,
    output sample_pkg::sample_t data_o
);
    import sample_pkg::*;

    sample_t mem [LEN];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_addr;

    assign rd_addr = rd_ptr + PTR_W'(offset_i);   // wraps with LEN a power of two

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (we_i) wr_ptr <= wr_ptr + 1'b1;
            if (pop_i) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // cleared so an unfilled window reads as silence
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LEN; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        data_o <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== verif/resampler_model.svh ====
// reference model: ring buffer contents and pointers, phase accumulators, dot product
`ifndef RESAMPLER_MODEL_SVH
`define RESAMPLER_MODEL_SVH

localparam int RB_LEN = 4 * HALFDEPTH;

logic signed [23:0] rb_mem [NUM_CH][RB_LEN];
int rb_rd [NUM_CH];
int rb_wr [NUM_CH];
int phase_acc [NUM_CH];

function automatic void reset_model();
    for (int c = 0; c < NUM_CH; c++) begin
        for (int i = 0; i < RB_LEN; i++) begin
            rb_mem[c][i] = '0;
        end
        rb_rd[c] = 0;
        rb_wr[c] = 0;
        phase_acc[c] = 0;
    end
endfunction

function automatic void store_sample(int c, logic signed [23:0] s);
    rb_mem[c][rb_wr[c]] = s;
    rb_wr[c] = (rb_wr[c] + 1) % RB_LEN;
endfunction

function automatic void advance_read(int c);
    rb_rd[c] = (rb_rd[c] + 1) % RB_LEN;
endfunction

// triangle over depth times (phase+1), tops out at 2^22
function automatic longint coef_for(int p, int d);
    return ((longint'(HALFDEPTH - d) * (longint'(p) + 1)) << 22) / (HALFDEPTH * NUM_FIR);
endfunction

function automatic longint clamp_acc(longint x);
    if (x > 64'sd2147483647) return 64'sd2147483647;
    if (x < -64'sd2147483648) return -64'sd2147483648;
    return x;
endfunction

// window sample at offset times coefficient, scaled by 2^-20 (fits 28 bits)
function automatic longint tap(int c, int off, int p, int d);
    longint s;
    s = longint'(rb_mem[c][(rb_rd[c] + off) % RB_LEN]);
    return (s * coef_for(p, d)) >>> 20;
endfunction

function automatic logic [23:0] predict_output(int c);
    longint acc;
    int fl;
    int fr;
    acc = 0;
    fl = phase_acc[c];
    fr = NUM_FIR - 1 - fl;
    for (int k = 0; k < HALFDEPTH; k++) begin
        acc = clamp_acc(acc + tap(c, 2 * HALFDEPTH - 1 - k, fr, HALFDEPTH - 1 - k));
    end
    for (int k = 0; k < HALFDEPTH; k++) begin
        acc = clamp_acc(acc + tap(c, HALFDEPTH - 1 - k, fl, k));
    end
    acc = acc >>> 4;   // guard bits
    if (acc > 64'sd8388607) acc = 64'sd8388607;
    if (acc < -64'sd8388608) acc = -64'sd8388608;
    return acc[23:0];
endfunction

// true when the phase wraps, i.e. the window moves by one sample
function automatic bit advance_phase(int c);
    phase_acc[c] = phase_acc[c] + DECIM;
    if (phase_acc[c] >= NUM_FIR) begin
        phase_acc[c] = phase_acc[c] - NUM_FIR;
        return 1'b1;
    end
    return 1'b0;
endfunction

`endif

// ==== verif/tb_resampler.sv ====
// testbench for resampler_top: clock, reset, random source and requests, model based checks
`timescale 1ns/100ps
`default_nettype none

module tb_resampler;

    localparam int NUM_CH = 4;
    localparam int HALFDEPTH = 8;
    localparam int NUM_FIR = 20;
    localparam int DECIM = 17;
    localparam int TIMESLICE = 32;
    localparam int ROTATION = NUM_CH * TIMESLICE;

    logic clk;
    logic rst;
    logic [NUM_CH-1:0] ack_i;
    logic [NUM_CH*24-1:0] data_i;
    logic [NUM_CH-1:0] pop_o;
    logic [NUM_CH-1:0] pop_i;
    logic [23:0] data_o;
    logic [NUM_CH-1:0] ack_o;

    integer seed = 32'h051efc88;
    int cyc;                          // cycle index since reset, slot position follows from it
    logic [NUM_CH-1:0] latched;       // requests waiting for their slot
    logic [NUM_CH-1:0] claimed;       // taken at slot start, ack due
    logic [NUM_CH-1:0] exp_pop;
    logic [NUM_CH-1:0] directed_req;
    int wr_wait [NUM_CH];             // source answer countdown after a pop
    int fill_mode [NUM_CH];           // 0 random, 1 +full scale, 2 -full scale
    bit rand_req;
    bit prime_all;
    int ack_cnt;
    int repeat_cnt;

    `include "resampler_model.svh"

    resampler_top #(
        .NUM_CH(NUM_CH),
        .HALFDEPTH(HALFDEPTH),
        .NUM_FIR(NUM_FIR),
        .DECIM(DECIM),
        .TIMESLICE(TIMESLICE)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .ack_i(ack_i),
        .data_i(data_i),
        .pop_o(pop_o),
        .pop_i(pop_i),
        .data_o(data_o),
        .ack_o(ack_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t ns: %s: got %0h, expected %0h", $time, what, got, exp));
        end
    endtask

    function automatic logic [23:0] new_sample(int c);
        logic [31:0] r;
        r = $random(seed);
        case (fill_mode[c])
            1: return 24'h7f_ffff;
            2: return 24'h80_0000;
            default: return r[23:0];
        endcase
    endfunction

    // inputs for the current cycle, then the request rule at its closing edge
    task automatic drive_inputs();
        logic [NUM_CH-1:0] req;
        logic [NUM_CH-1:0] wr;
        logic [NUM_CH*24-1:0] dat;
        logic [23:0] s;
        int slot_ch;
        req = directed_req;
        wr = '0;
        dat = '0;
        directed_req = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            if (rand_req && ($unsigned($random(seed)) % 64) == 0) req[c] = 1'b1;
            if (req[c] && latched[c]) repeat_cnt++;
            if (prime_all || wr_wait[c] == 1) begin
                s = new_sample(c);
                wr[c] = 1'b1;
                dat[24*c +: 24] = s;
                store_sample(c, s);
            end
            if (wr_wait[c] > 0) wr_wait[c]--;
        end
        pop_i = req;
        ack_i = wr;
        data_i = dat;
        if (cyc % TIMESLICE == 0) begin
            slot_ch = (cyc / TIMESLICE) % NUM_CH;
            claimed[slot_ch] = latched[slot_ch];
            latched[slot_ch] = 1'b0;
        end
        latched = latched | req;
    endtask

    task automatic check_outputs();
        int ch;
        check_value(32'(pop_o), 32'(exp_pop), "pop_o strobes");
        for (int c = 0; c < NUM_CH; c++) begin
            if (exp_pop[c]) begin
                advance_read(c);
                wr_wait[c] = 2 + int'($unsigned($random(seed)) % 3);
            end
        end
        exp_pop = '0;
        if (ack_o != '0) begin
            check_value(32'($countones(ack_o)), 32'd1, "ack_o one-hot");
            ch = 0;
            for (int c = 0; c < NUM_CH; c++) begin
                if (ack_o[c]) ch = c;
            end
            check_value(32'(claimed[ch]), 32'd1, "ack_o only on a requested channel");
            check_value(32'(data_o), 32'(predict_output(ch)), "data_o against model");
            if (fill_mode[ch] != 0) begin
                check_value(32'(data_o), (fill_mode[ch] == 1) ? 32'h7f_ffff : 32'h80_0000,
                            "data_o for a full-scale window");
            end
            exp_pop[ch] = advance_phase(ch);   // pop follows one cycle later
            claimed[ch] = 1'b0;
            ack_cnt++;
        end
        if (cyc % TIMESLICE == TIMESLICE - 1) begin
            check_value(32'(claimed[(cyc / TIMESLICE) % NUM_CH]), 32'd0, "ack within its slot");
        end
    endtask

    task automatic run_cycle();
        drive_inputs();
        @(posedge clk);
        #1;
        cyc++;
        check_outputs();
    endtask

    function automatic bit is_drained();
        bit busy;
        busy = (latched != '0) || (claimed != '0) || (exp_pop != '0);
        for (int c = 0; c < NUM_CH; c++) begin
            if (wr_wait[c] != 0) busy = 1'b1;
        end
        return !busy;
    endfunction

    task automatic wait_drain(input int limit, input string what);
        int n;
        n = 0;
        run_cycle();
        while (!is_drained()) begin
            if (n == limit) begin
                abort_run($sformatf("timeout: %s still pending after %0d cycles", what, limit));
            end else begin
                run_cycle();
                n++;
            end
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        pop_i = '0;
        ack_i = '0;
        data_i = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_model();
        cyc = 0;
        latched = '0;
        claimed = '0;
        exp_pop = '0;
        directed_req = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            wr_wait[c] = 0;
        end
        check_outputs();
    endtask

    task automatic prime_buffers();
        prime_all = 1'b1;
        repeat (2 * HALFDEPTH) run_cycle();
        prime_all = 1'b0;
    endtask

    initial begin
        rand_req = 1'b0;
        prime_all = 1'b0;
        ack_cnt = 0;
        repeat_cnt = 0;
        for (int c = 0; c < NUM_CH; c++) begin
            fill_mode[c] = 0;
        end
        apply_reset();
        prime_buffers();
        repeat (3 * ROTATION) run_cycle();   // idle rotations

        rand_req = 1'b1;
        repeat (40 * ROTATION) run_cycle();
        rand_req = 1'b0;
        wait_drain(3 * ROTATION, "random requests");
        check_value(32'(ack_cnt >= 50), 32'd1, "enough random outputs checked");
        check_value(32'(repeat_cnt > 0), 32'd1, "repeated requests issued");

        // full-scale windows, channel 0 positive and channel 1 negative
        fill_mode[0] = 1;
        fill_mode[1] = 2;
        apply_reset();
        prime_buffers();
        repeat (3) begin
            directed_req = NUM_CH'(3);
            wait_drain(3 * ROTATION, "full-scale requests");
        end
        $display("checked %0d outputs, %0d repeated requests", ack_cnt, repeat_cnt);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
